/* source/core_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core-level types for the multi-cycle RV32I core
// One instruction in flight, so the FSM has 5 states
// Reset address is only a default, the top level overrides it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package core_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] xlen_t;   // Data and address word
	typedef logic [4:0]      reg_addr_t;

	localparam xlen_t RESET_ADDR_DEFAULT = 32'h8000_0000;

	// Sequencing FSM
	typedef enum logic [2:0] {
		FETCH   = 3'd0,
		DECODE  = 3'd1,
		EXECUTE = 3'd2,
		MEMR    = 3'd3,
		MEMW    = 3'd4
	} state_e;

	typedef enum logic [2:0] {
		ADD = 3'd0,
		SLL = 3'd1,
		SRL = 3'd2,
		SRA = 3'd3,
		XOR = 3'd4,
		OR  = 3'd5,
		AND = 3'd6
	} alu_op_e;

	// Comparator, inversion handled separately
	typedef enum logic [1:0] {
		EQ  = 2'd0,
		LT  = 2'd1,
		LTU = 2'd2
	} cmp_op_e;

endpackage

`default_nettype wire

/* source/rv32i_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I instruction set definitions
// Only the major opcodes the core executes are listed
// Anything else decodes as C_NOP
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rv32i_pkg;

	// Major opcodes in instr[6:0]
	typedef enum logic [6:0] {
		LUI      = 7'b0110111,
		AUIPC    = 7'b0010111,
		JAL      = 7'b1101111,
		JALR     = 7'b1100111,
		BRANCH   = 7'b1100011,
		LOAD     = 7'b0000011,
		STORE    = 7'b0100011,
		OP_IMM   = 7'b0010011,
		OP_REG   = 7'b0110011,
		MISC_MEM = 7'b0001111
	} opcode_e;

	// Nine classes need four bits
	typedef enum logic [3:0] {
		C_LUI, C_AUIPC, C_JAL, C_JALR, C_BRANCH, C_LOAD, C_STORE, C_ALU, C_NOP
	} instr_class_e;

	typedef struct packed {
		instr_class_e        cls;
		core_pkg::reg_addr_t rs1;
		core_pkg::reg_addr_t rs2;
		core_pkg::reg_addr_t rd;
		core_pkg::xlen_t     imm;      // Already sign extended for the format
		core_pkg::alu_op_e   alu_op;
		core_pkg::cmp_op_e   cmp_op;
		logic                rs2_op;   // Second operand from rs2
		logic                sub;      // Negate rs2
		logic                slt;      // Result is the compare bit
		logic                inv_cond; // BNE, BGE, BGEU
	} decoded_t;

endpackage

`default_nettype wire

/* source/regfile_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file port bundle
// Two async read ports, one write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface regfile_if;
	import core_pkg::*;

	reg_addr_t ra_raddr;
	reg_addr_t rb_raddr;
	xlen_t     ra_rdata;
	xlen_t     rb_rdata;
	reg_addr_t rd_waddr;
	xlen_t     rd_wdata;
	logic      rd_wen;

	modport user (output ra_raddr, rb_raddr, rd_waddr, rd_wdata, rd_wen,
		input ra_rdata, rb_rdata);
	modport store (input ra_raddr, rb_raddr, rd_waddr, rd_wdata, rd_wen,
		output ra_rdata, rb_rdata);
endinterface

`default_nettype wire

/* source/alu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational ALU
// Shifts take the amount from a[4:0], value from b
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire core_pkg::xlen_t   a,
	input  wire core_pkg::xlen_t   b,
	input  wire core_pkg::alu_op_e op,
	output core_pkg::xlen_t        result
);
	import core_pkg::*;

	logic [4:0] shamt;

	assign shamt = a[4:0];

	always_comb begin
		case (op)
			ADD: result = a + b; // Also SUB, a arrives negated
			SLL: result = b << shamt;
			SRL: result = b >> shamt;
			SRA: result = xlen_t'($signed(b) >>> shamt);
			XOR: result = a ^ b;
			OR:  result = a | b;
			AND: result = a & b;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/regfile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 register file
// Async reads, write on the rising edge
// x0 always reads as zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input wire logic  clock,
	input wire logic  reset,
	regfile_if.store  rf
);
	import core_pkg::*;

	xlen_t regs [32];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (rf.rd_wen) begin
			regs[rf.rd_waddr] <= rf.rd_wdata;
		end
	end

	assign rf.ra_rdata = (rf.ra_raddr == '0) ? '0 : regs[rf.ra_raddr];
	assign rf.rb_rdata = (rf.rb_raddr == '0) ? '0 : regs[rf.rb_raddr];

endmodule

`default_nettype wire

/* source/instr_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational RV32I decoder
// Unknown opcodes and FENCE decode as C_NOP
// SLT/SLTU use ADD, result comes from compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  wire logic [31:0]    instr,
	output rv32i_pkg::decoded_t dec
);
	import core_pkg::*;
	import rv32i_pkg::*;

	opcode_e     opcode;
	logic [2:0]  funct3;
	xlen_t       imm_i;
	xlen_t       imm_s;
	xlen_t       imm_b;
	xlen_t       imm_u;
	xlen_t       imm_j;

	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		dec        = '0;
		dec.cls    = C_NOP;
		dec.rs1    = instr[19:15]; // Register fields never move
		dec.rs2    = instr[24:20];
		dec.rd     = instr[11:7];
		dec.alu_op = ADD;
		dec.cmp_op = EQ;
		case (opcode)
			LUI:    begin dec.cls = C_LUI;   dec.imm = imm_u; end
			AUIPC:  begin dec.cls = C_AUIPC; dec.imm = imm_u; end
			JAL:    begin dec.cls = C_JAL;   dec.imm = imm_j; end
			JALR:   begin dec.cls = C_JALR;  dec.imm = imm_i; end
			LOAD:   begin dec.cls = C_LOAD;  dec.imm = imm_i; end
			STORE:  begin dec.cls = C_STORE; dec.imm = imm_s; end
			BRANCH: begin
				dec.cls      = C_BRANCH;
				dec.imm      = imm_b;
				dec.rs2_op   = 1'b1;
				dec.inv_cond = funct3[0];
				case (funct3[2:1])
					2'b10:   dec.cmp_op = LT;
					2'b11:   dec.cmp_op = LTU;
					default: dec.cmp_op = EQ;
				endcase
			end
			OP_IMM, OP_REG: begin
				dec.cls    = C_ALU;
				dec.imm    = imm_i; // Low 5 bits are shamt for shifts
				dec.rs2_op = (opcode == OP_REG);
				case (funct3)
					3'b000: dec.sub = (opcode == OP_REG) && instr[30];
					3'b001: dec.alu_op = SLL;
					3'b010: begin dec.slt = 1'b1; dec.cmp_op = LT; end
					3'b011: begin dec.slt = 1'b1; dec.cmp_op = LTU; end
					3'b100: dec.alu_op = XOR;
					3'b101: dec.alu_op = instr[30] ? SRA : SRL;
					3'b110: dec.alu_op = OR;
					default: dec.alu_op = AND;
				endcase
			end
			default: dec.cls = C_NOP;
		endcase
	end

endmodule

`default_nettype wire

/* source/execute_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand select, compare, writeback, next PC
// Write timing comes from commit; this unit
// only decides whether the write happens
// Misaligned targets are not trapped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  wire rv32i_pkg::decoded_t dec,
	input  wire core_pkg::xlen_t     pc,
	input  wire core_pkg::state_e    state,
	input  wire logic                commit,
	input  wire core_pkg::xlen_t     drdata,
	input  wire core_pkg::xlen_t     alu_result,
	output core_pkg::xlen_t          alu_a,
	output core_pkg::xlen_t          alu_b,
	output core_pkg::alu_op_e        alu_op,
	output core_pkg::xlen_t          next_pc,
	output core_pkg::xlen_t          dwdata,
	regfile_if.user                  rf
);
	import core_pkg::*;
	import rv32i_pkg::*;

	xlen_t pc_plus4;
	xlen_t cmp_b;
	logic  cmp_out;
	logic  taken;
	logic  writes_rd;

	assign rf.ra_raddr = dec.rs1;
	assign rf.rb_raddr = dec.rs2;
	assign rf.rd_waddr = dec.rd;

	assign pc_plus4 = pc + 32'd4;

	// a is the immediate side, b the value side
	assign alu_a = (dec.cls == C_ALU && dec.rs2_op) ?
		(dec.sub ? -rf.rb_rdata : rf.rb_rdata) : dec.imm;
	always_comb begin
		case (dec.cls)
			C_LUI: alu_b = '0;
			C_AUIPC, C_JAL, C_BRANCH: alu_b = pc;
			default: alu_b = rf.ra_rdata;
		endcase
	end
	assign alu_op = dec.alu_op;

	assign cmp_b = dec.rs2_op ? rf.rb_rdata : dec.imm;
	always_comb begin
		case (dec.cmp_op)
			LT:      cmp_out = $signed(rf.ra_rdata) < $signed(cmp_b);
			LTU:     cmp_out = rf.ra_rdata < cmp_b;
			default: cmp_out = rf.ra_rdata == cmp_b;
		endcase
	end
	assign taken = (dec.cls == C_BRANCH) && (cmp_out ^ dec.inv_cond);

	always_comb begin
		if (state == MEMR) rf.rd_wdata = drdata;             // Load data
		else if (dec.cls == C_JAL || dec.cls == C_JALR) rf.rd_wdata = pc_plus4;
		else if (dec.slt) rf.rd_wdata = {31'b0, cmp_out};
		else rf.rd_wdata = alu_result;
	end

	assign writes_rd = (dec.cls != C_BRANCH) && (dec.cls != C_STORE) && (dec.cls != C_NOP);
	assign rf.rd_wen = commit && writes_rd && (dec.rd != '0);

	always_comb begin
		if (dec.cls == C_JALR) next_pc = {alu_result[31:1], 1'b0};
		else if (dec.cls == C_JAL || taken) next_pc = alu_result;
		else next_pc = pc_plus4;
	end

	assign dwdata = rf.rb_rdata; // Store data is always rs2

endmodule

`default_nettype wire

/* source/core_control.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequencing FSM, PC and instruction register
// ivalid is registered so it stays low in reset
// Two idle fetch cycles between non-memory instructions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module core_control #(
	parameter core_pkg::xlen_t RESET_ADDR = core_pkg::RESET_ADDR_DEFAULT
) (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire core_pkg::xlen_t     idata,
	input  wire logic                iready,
	input  wire logic                dready,
	input  wire rv32i_pkg::decoded_t dec,
	input  wire core_pkg::xlen_t     next_pc,
	input  wire core_pkg::xlen_t     alu_result,
	output logic [31:0]              instr,
	output core_pkg::xlen_t          pc,
	output core_pkg::state_e         state,
	output logic                     commit,
	output core_pkg::xlen_t          iaddr,
	output logic                     ivalid,
	output core_pkg::xlen_t          daddr,
	output logic [3:0]               dstrb,
	output logic                     dwrite,
	output logic                     dvalid
);
	import core_pkg::*;
	import rv32i_pkg::*;

	state_e next_state;
	logic   done;      // Instruction completes this edge

	always_comb begin
		next_state = state;
		case (state)
			FETCH: if (ivalid && iready) next_state = DECODE;
			DECODE: next_state = EXECUTE;
			EXECUTE: begin
				case (dec.cls)
					C_LOAD:  next_state = MEMR;
					C_STORE: next_state = MEMW;
					default: next_state = FETCH;
				endcase
			end
			MEMR, MEMW: if (dready) next_state = FETCH;
			default: next_state = FETCH;
		endcase
	end

	assign done = (state == EXECUTE && next_state == FETCH) ||
		((state == MEMR || state == MEMW) && dready);
	assign commit = done && (state != MEMW); // Stores never write a register

	always_ff @(posedge clock) begin
		if (reset) begin
			state  <= FETCH;
			ivalid <= 1'b0;
			pc     <= RESET_ADDR;
		end else begin
			state  <= next_state;
			ivalid <= (next_state == FETCH); // High for the whole FETCH stay
			if (done) pc <= next_pc;
		end
	end

	always_ff @(posedge clock) begin
		if (ivalid && iready) instr <= idata;
	end

	assign iaddr  = {pc[31:2], 2'b00};
	assign dvalid = (state == MEMR) || (state == MEMW);
	assign dwrite = (state == MEMW);
	assign daddr  = {alu_result[31:2], 2'b00}; // Word accesses only
	assign dstrb  = 4'hf;

endmodule

`default_nettype wire

/* source/fwrisc_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multi-cycle RV32I core, top level
// No CSRs, no exceptions, word accesses only
// Bus valids hold until the matching ready
// dstrb is always 4'hf
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fwrisc_core #(
	parameter core_pkg::xlen_t RESET_ADDR = core_pkg::RESET_ADDR_DEFAULT
) (
	input  wire logic            clock,
	input  wire logic            reset,
	output core_pkg::xlen_t      iaddr,
	input  wire core_pkg::xlen_t idata,
	output logic                 ivalid,
	input  wire logic            iready,
	output core_pkg::xlen_t      daddr,
	output core_pkg::xlen_t      dwdata,
	input  wire core_pkg::xlen_t drdata,
	output logic [3:0]           dstrb,
	output logic                 dwrite,
	output logic                 dvalid,
	input  wire logic            dready
);
	import core_pkg::*;
	import rv32i_pkg::*;

	logic [31:0] instr;
	xlen_t       pc;
	state_e      state;
	logic        commit;
	decoded_t    dec;
	xlen_t       next_pc;
	xlen_t       alu_result;
	xlen_t       alu_a;
	xlen_t       alu_b;
	alu_op_e     alu_op;

	regfile_if rf_bus();

	core_control #(.RESET_ADDR(RESET_ADDR)) u_control (
		.clock(clock), .reset(reset), .idata(idata), .iready(iready), .dready(dready),
		.dec(dec), .next_pc(next_pc), .alu_result(alu_result),
		.instr(instr), .pc(pc), .state(state), .commit(commit),
		.iaddr(iaddr), .ivalid(ivalid), .daddr(daddr), .dstrb(dstrb),
		.dwrite(dwrite), .dvalid(dvalid)
	);

	instr_decoder u_decoder (.instr(instr), .dec(dec));

	execute_unit u_execute (
		.dec(dec), .pc(pc), .state(state), .commit(commit), .drdata(drdata),
		.alu_result(alu_result), .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op),
		.next_pc(next_pc), .dwdata(dwdata), .rf(rf_bus.user)
	);

	alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result));

	regfile u_regfile (.clock(clock), .reset(reset), .rf(rf_bus.store));

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and power-on reset
// 20 ns period, reset high for 10 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic clock,
	output logic reset
);
	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#2 reset = 1'b0; // Same drive offset as the stimulus
	end
endmodule

`default_nettype wire

/* verif/core_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus protocol assertions, bound into the core
// Checks are off while reset is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module core_assert (
	input wire logic            clock,
	input wire logic            reset,
	input wire logic            ivalid,
	input wire logic            iready,
	input wire core_pkg::xlen_t iaddr,
	input wire logic            dvalid,
	input wire logic            dready,
	input wire logic            dwrite,
	input wire core_pkg::xlen_t daddr,
	input wire core_pkg::xlen_t dwdata
);
	int fail_count = 0; // Read by the testbench at the end

	a_one_bus: assert property (@(posedge clock) disable iff (reset) !(ivalid && dvalid))
		else begin fail_count++; $error("ivalid and dvalid high together"); end

	a_write_valid: assert property (@(posedge clock) disable iff (reset) dwrite |-> dvalid)
		else begin fail_count++; $error("dwrite high without dvalid"); end

	a_data_hold: assert property (@(posedge clock) disable iff (reset)
		(dvalid && !dready) |=> (dvalid && $stable(daddr) && $stable(dwdata)))
		else begin fail_count++; $error("data request changed before dready"); end

	a_iaddr_align: assert property (@(posedge clock) disable iff (reset) iaddr[1:0] == 2'b00)
		else begin fail_count++; $error("iaddr not word aligned"); end
endmodule

bind fwrisc_core core_assert i_core_assert (.*);

`default_nettype wire

/* verif/tb_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the RV32I core
// imem starts at RESET_ADDR, dmem holds 64 words at 0x1000
// Programs end in a self-looping JAL at the halt address
// Unwritten memory returns an address-derived word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_top;
	import core_pkg::*;
	import rv32i_pkg::*;

	localparam xlen_t RESET_ADDR = RESET_ADDR_DEFAULT;
	localparam xlen_t DMEM_BASE  = 32'h0000_1000;
	localparam logic [31:0] NOP  = 32'h0000_0013;

	logic clock, reset, core_hold, dut_reset;
	xlen_t iaddr, idata, daddr, dwdata, drdata;
	logic ivalid, iready, dwrite, dvalid, dready;
	logic [3:0] dstrb;

	xlen_t imem [128];
	xlen_t dmem [64];
	xlen_t ioff, doff;
	xlen_t prog[$], exp_fetch[$], exp_vals[$], fetch_log[$], d_log[$];
	string exp_names[$];
	int    gap_log[$];
	xlen_t lfsr_state = 32'd94422;
	xlen_t halt_addr;
	bit    halt_seen, random_delays;
	int    mismatches = 0, other_errors = 0, gap_count = 0;
	int    cycle_count = 0, budget = 300;
	logic  ifire, dfire, dw;
	xlen_t fa, da, dd;
	logic [3:0] ds;
	int    idelay, ddelay;

	tb_clock_gen i_clock_gen (.clock(clock), .reset(reset));

	assign dut_reset = reset | core_hold;

	fwrisc_core #(.RESET_ADDR(RESET_ADDR)) i_fwrisc_core (
		.clock(clock), .reset(dut_reset), .iaddr(iaddr), .idata(idata), .ivalid(ivalid),
		.iready(iready), .daddr(daddr), .dwdata(dwdata), .drdata(drdata), .dstrb(dstrb),
		.dwrite(dwrite), .dvalid(dvalid), .dready(dready)
	);

	function automatic xlen_t fill_word(input xlen_t addr);
		return {addr[15:0], addr[31:16]} ^ 32'h6b1d_e2f7;
	endfunction

	always_comb begin
		ioff  = iaddr - RESET_ADDR;
		idata = (ioff < 32'd512) ? imem[ioff[8:2]] : fill_word(iaddr);
		doff  = daddr - DMEM_BASE;
		drdata = (doff < 32'd256) ? dmem[doff[7:2]] : fill_word(daddr);
	end

	// Galois LFSR with taps 32, 30, 26 and 25
	function logic rand_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = out ? ((lfsr_state >> 1) ^ 32'ha300_0000) : (lfsr_state >> 1);
		return out;
	endfunction

	function xlen_t rand_bits(input int n);
		xlen_t v;
		v = '0;
		for (int i = 0; i < n; i++) v = {v[30:0], rand_bit()};
		return v;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic xlen_t bit_word(input logic c);
		return {31'b0, c};
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input xlen_t a, input xlen_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input string what, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t ns: address %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function xlen_t here();
		return RESET_ADDR + 32'(4 * prog.size());
	endfunction

	task emit(input logic [31:0] w, input bit runs = 1'b1);
		if (runs) exp_fetch.push_back(here()); // Skipped words are never fetched
		prog.push_back(w);
	endtask

	task load_const(input logic [4:0] rd, input xlen_t v);
		xlen_t up;
		up = (v + 32'h800) >> 12;
		emit(enc_u(up[19:0], rd, LUI));
		emit(enc_i(v[11:0], rd, 3'd0, rd, OP_IMM));
	endtask

	task store_result(input logic [4:0] rs2, input xlen_t expv, input string name);
		emit(enc_s(12'(4 * exp_vals.size()), rs2, 5'd31));
		exp_vals.push_back(expv);
		exp_names.push_back(name);
	endtask

	task start_program();
		prog.delete();
		exp_fetch.delete();
		exp_vals.delete();
		exp_names.delete();
		emit(enc_u(20'h1, 5'd31, LUI)); // x31 is the result base
	endtask

	task run_program(input bit rand_on);
		halt_addr = here();
		emit(enc_j(21'd0, 5'd0));
		budget += 400 * prog.size() + 50;
		@(posedge clock);
		#2 core_hold = 1'b1;
		for (int i = 0; i < 128; i++) imem[i] = fill_word(RESET_ADDR + 32'(4 * i));
		for (int i = 0; i < 64; i++) dmem[i] = fill_word(DMEM_BASE + 32'(4 * i));
		foreach (prog[i]) imem[i] = prog[i];
		random_delays = rand_on;
		for (int i = 0; i < 10; i++) begin
			@(negedge clock);
			if (i > 0) begin // Registered ivalid clears one edge in
				check_word("ivalid in reset", bit_word(ivalid), 32'd0);
				check_word("dvalid in reset", bit_word(dvalid), 32'd0);
			end
		end
		// The edge that entered reset logged a fetch the core never took
		fetch_log.delete();
		gap_log.delete();
		d_log.delete();
		halt_seen = 1'b0;
		@(posedge clock);
		#2 core_hold = 1'b0;
		gap_count = 0;
		while (!halt_seen) @(posedge clock);
	endtask

	task check_results();
		foreach (exp_vals[i]) check_word(exp_names[i], dmem[i], exp_vals[i]);
	endtask

	task check_fetches();
		foreach (exp_fetch[i]) begin
			if (i >= fetch_log.size()) begin
				other_errors++;
				$display("ERROR at %0t ns: fewer fetches than the program needs", $time);
				break;
			end
			check_addr("of fetch", fetch_log[i], exp_fetch[i]);
		end
	endtask

	task test_reset();
		start_program();
		emit(enc_i(12'd5, 5'd0, 3'd0, 5'd1, OP_IMM));
		store_result(5'd1, 32'd5, "x1 after reset");
		run_program(1'b0);
		if (fetch_log.size() == 0) begin
			other_errors++;
			$display("ERROR at %0t ns: no fetch after reset", $time);
		end else check_addr("of first fetch", fetch_log[0], 32'h8000_0000);
		check_results();
	endtask

	task alu_case(input logic [31:0] instr, input xlen_t expv, input string name);
		emit(instr);
		store_result(5'd3, expv, name);
	endtask

	task test_alu();
		xlen_t a, b, simm;
		logic [11:0] imm;
		logic [4:0] sh;
		a = rand_bits(32);
		b = rand_bits(32);
		imm = 12'(rand_bits(12));
		sh = 5'(rand_bits(5));
		simm = {{20{imm[11]}}, imm};
		start_program();
		load_const(5'd1, a);
		load_const(5'd2, b);
		alu_case(enc_r(7'h00, 2, 1, 0, 3), a + b, "ADD");
		alu_case(enc_r(7'h20, 2, 1, 0, 3), a - b, "SUB");
		alu_case(enc_r(7'h00, 2, 1, 1, 3), a << b[4:0], "SLL");
		alu_case(enc_r(7'h00, 2, 1, 2, 3), bit_word($signed(a) < $signed(b)), "SLT");
		alu_case(enc_r(7'h00, 2, 1, 3, 3), bit_word(a < b), "SLTU");
		alu_case(enc_r(7'h00, 2, 1, 4, 3), a ^ b, "XOR");
		alu_case(enc_r(7'h00, 2, 1, 5, 3), a >> b[4:0], "SRL");
		alu_case(enc_r(7'h20, 2, 1, 5, 3), xlen_t'($signed(a) >>> b[4:0]), "SRA");
		alu_case(enc_r(7'h00, 2, 1, 6, 3), a | b, "OR");
		alu_case(enc_r(7'h00, 2, 1, 7, 3), a & b, "AND");
		alu_case(enc_i(imm, 1, 0, 3, OP_IMM), a + simm, "ADDI");
		alu_case(enc_i(imm, 1, 2, 3, OP_IMM), bit_word($signed(a) < $signed(simm)), "SLTI");
		alu_case(enc_i(imm, 1, 3, 3, OP_IMM), bit_word(a < simm), "SLTIU");
		alu_case(enc_i(imm, 1, 4, 3, OP_IMM), a ^ simm, "XORI");
		alu_case(enc_i(imm, 1, 6, 3, OP_IMM), a | simm, "ORI");
		alu_case(enc_i(imm, 1, 7, 3, OP_IMM), a & simm, "ANDI");
		alu_case(enc_i({7'h00, sh}, 1, 1, 3, OP_IMM), a << sh, "SLLI");
		alu_case(enc_i({7'h00, sh}, 1, 5, 3, OP_IMM), a >> sh, "SRLI");
		alu_case(enc_i({7'h20, sh}, 1, 5, 3, OP_IMM), xlen_t'($signed(a) >>> sh), "SRAI");
		emit(enc_r(7'h00, 2, 1, 0, 0)); // Write to x0 must be dropped
		store_result(5'd0, 32'd0, "x0");
		run_program(1'b0);
		check_results();
	endtask

	task test_upper();
		xlen_t u1, u2, p;
		u1 = rand_bits(20);
		u2 = rand_bits(20);
		start_program();
		emit(enc_u(u1[19:0], 5'd5, LUI));
		store_result(5'd5, u1 << 12, "LUI");
		p = here();
		emit(enc_u(u2[19:0], 5'd6, AUIPC));
		store_result(5'd6, (u2 << 12) + p, "AUIPC");
		run_program(1'b0);
		check_results();
	endtask

	task test_control();
		logic [2:0] f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		xlen_t vals [3] = '{32'd0, 32'hffff_fffb, 32'd3};
		logic [4:0] r1, r2;
		xlen_t p;
		start_program();
		load_const(5'd1, vals[1]);
		load_const(5'd2, vals[2]);
		foreach (f3s[k]) begin
			for (int j = 0; j < 3; j++) begin
				r1 = (j == 2) ? 5'd2 : 5'd1;
				r2 = (j == 0) ? 5'd1 : ((j == 1) ? 5'd2 : 5'd1);
				emit(enc_b(13'd8, r2, r1, f3s[k]));
				emit(NOP, !branch_taken(f3s[k], vals[r1], vals[r2]));
			end
		end
		p = here();
		emit(enc_j(21'd8, 5'd7));
		emit(NOP, 1'b0);
		store_result(5'd7, p + 4, "JAL link");
		p = here();
		load_const(5'd8, p + 16);
		emit(enc_i(12'd1, 5'd8, 3'd0, 5'd9, JALR)); // Odd target has bit 0 cleared
		emit(NOP, 1'b0);
		store_result(5'd9, p + 12, "JALR link");
		run_program(1'b1);
		check_fetches();
		check_results();
	endtask

	task test_loads();
		start_program();
		emit(enc_i(12'h042, 5'd31, 3'b010, 5'd10, LOAD)); // Low address bits are dropped
		emit(enc_s(12'h083, 5'd10, 5'd31));
		run_program(1'b1);
		check_word("copied word", dmem[32], fill_word(DMEM_BASE + 32'h40));
		if (d_log.size() < 2) begin
			other_errors++;
			$display("ERROR at %0t ns: load and store did not both reach the bus", $time);
		end else begin
			check_addr("of load", d_log[0], DMEM_BASE + 32'h40);
			check_addr("of store", d_log[1], DMEM_BASE + 32'h80);
		end
	endtask

	task test_fetch_spacing();
		start_program();
		for (int i = 0; i < 6; i++) begin
			emit(enc_i(12'(i + 1), 5'(i + 1), 3'(i % 2 * 4), 5'(i + 2), OP_IMM));
		end
		run_program(1'b0);
		for (int i = 1; i < exp_fetch.size() && i < gap_log.size(); i++)
			check_word("ivalid low cycles", xlen_t'(gap_log[i]), 32'd2);
		check_fetches();
	endtask

	// Bus responder samples mid-cycle and drives 2 ns after the edge
	initial begin
		iready = 1'b1;
		dready = 1'b1;
		core_hold = 1'b1;
		idelay = 0;
		ddelay = 0;
		forever begin
			@(negedge clock);
			ifire = ivalid && iready;
			fa = iaddr;
			dfire = dvalid && dready;
			dw = dwrite;
			da = daddr;
			dd = dwdata;
			ds = dstrb;
			if (!ivalid && !dut_reset) gap_count++;
			@(posedge clock);
			#2;
			if (ifire) begin
				fetch_log.push_back(fa);
				gap_log.push_back(gap_count);
				gap_count = 0;
				if (fa == halt_addr) halt_seen = 1'b1;
			end
			if (dfire) begin
				d_log.push_back(da);
				check_word("dstrb", {28'b0, ds}, 32'hf);
				check_word("daddr low bits", {30'b0, da[1:0]}, 32'd0);
				if (dw && (da - DMEM_BASE) < 32'd256)
					dmem[6'((da - DMEM_BASE) >> 2)] = dd;
			end
			if (!random_delays) begin
				iready = 1'b1;
				dready = 1'b1;
			end else begin
				if (ifire) begin
					iready = 1'b0;
					idelay = int'(rand_bits(2));
				end else if (!iready) begin
					if (idelay == 0)
						iready = 1'b1;
					else
						idelay--;
				end
				if (dfire) begin
					dready = 1'b0;
					ddelay = int'(rand_bits(2));
				end else if (!dready) begin
					if (ddelay == 0)
						dready = 1'b1;
					else
						ddelay--;
				end
			end
		end
	end

	// Watchdog budget grows by 400 cycles per loaded instruction
	initial begin
		forever begin
			@(posedge clock);
			cycle_count++;
			if (cycle_count > budget) begin
				$display("Timeout: core did not reach the halt address in %0d cycles", budget);
				$display("STATUS: FAIL");
				$finish;
			end
		end
	end

	initial begin
		@(negedge reset);
		test_reset();
		test_alu();
		test_upper();
		test_control();
		test_loads();
		test_fetch_spacing();
		repeat (2) @(posedge clock);
		$display("Done: %0d mismatches, %0d other errors, %0d assertion failures",
			mismatches, other_errors, i_fwrisc_core.i_core_assert.fail_count);
		if (mismatches == 0 && other_errors == 0 && i_fwrisc_core.i_core_assert.fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end
endmodule

`default_nettype wire

/* files.f */
source/core_pkg.sv
source/rv32i_pkg.sv
source/regfile_if.sv
source/alu.sv
source/regfile.sv
source/instr_decoder.sv
source/execute_unit.sv
source/core_control.sv
source/fwrisc_core.sv
verif/tb_clock_gen.sv
verif/core_assert.sv
verif/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     = --timing --assert -Wno-fatal
TOP       = tb_top
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
